// ==== verilog/nes_bus_pkg.sv ====
/*
 * Console-side bus widths, clock-enable phases and reset timing.
 * The console advances one step every fourth clk, in the phase MEM_SLOT_PHASE.
 */
package nes_bus_pkg;

	localparam int MEM_ADDR_WIDTH = 22;	// Covers PRG and CHR regions

	typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
	typedef logic [7:0] byte_t;
	typedef logic [1:0] ce_phase_t;	// Four-phase clock enable

	// Console runs and staged writes land in this phase
	localparam ce_phase_t MEM_SLOT_PHASE = 2'd3;

	// Hold time of the reset that follows a download
	typedef logic [7:0] reset_count_t;
	localparam reset_count_t DOWNLOAD_RESET_CYCLES = 8'd255;

endpackage

// ==== verilog/ines_pkg.sv ====
/*
 * iNES header layout and the bit fields of the 32-bit mapper-flag word.
 * Only the 16-byte header is described; trainers are not supported.
 */
package ines_pkg;

	localparam int HEADER_BYTES = 16;

	typedef nes_bus_pkg::byte_t header_t [HEADER_BYTES];

	// Byte offsets inside the header
	localparam int MAGIC_0 = 0;
	localparam int MAGIC_1 = 1;
	localparam int MAGIC_2 = 2;
	localparam int MAGIC_3 = 3;
	localparam int PRG_PAGES_OFS = 4;	// 16 KB units
	localparam int CHR_PAGES_OFS = 5;	// 8 KB units, 0 means CHR RAM
	localparam int FLAGS6_OFS = 6;
	localparam int FLAGS7_OFS = 7;
	localparam int MAPPER2_OFS = 8;

	// "NES" followed by MS-DOS end of file
	localparam nes_bus_pkg::byte_t NES_MAGIC [4] = '{8'h4E, 8'h45, 8'h53, 8'h1A};

	// Bits inside flags 6 and flags 7
	localparam int MIRROR_SRC_BIT = 0;
	localparam int TRAINER_BIT = 2;
	localparam int FOUR_SCREEN_SRC_BIT = 3;
	localparam logic [1:0] NES20_ID = 2'b10;	// Flags 7 bits 3..2

	localparam int PRG_PAGE_SHIFT = 14;
	localparam int CHR_PAGE_SHIFT = 13;

	localparam nes_bus_pkg::mem_addr_t PRG_BASE = '0;
	localparam nes_bus_pkg::mem_addr_t CHR_BASE =
		{1'b1, {(nes_bus_pkg::MEM_ADDR_WIDTH-1){1'b0}}};

	// Mapper-flag word, bits 31..25 stay zero
	localparam int MAPPER_LSB = 0;	// 8 bits
	localparam int PRG_SIZE_LSB = 8;	// 3 bits
	localparam int CHR_SIZE_LSB = 11;	// 3 bits
	localparam int MIRROR_BIT = 14;
	localparam int CHR_RAM_BIT = 15;
	localparam int FOUR_SCREEN_BIT = 16;
	localparam int NES20_MAPPER_LSB = 17;	// 8 bits

endpackage

// ==== verilog/mapper_flags_decode.sv ====
/*
 * Purely combinational; the caller must hold the header stable.
 * Size codes saturate at 7 above 64 pages.
 */
module mapper_flags_decode (
	input ines_pkg::header_t header,
	input logic invert_mirroring,
	output logic [31:0] flags
);
	import nes_bus_pkg::*;
	import ines_pkg::*;

	// Smallest power of two that holds the page count
	function automatic logic [2:0] size_code(input byte_t pages);
		logic [2:0] code;
		code = 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if (pages <= (9'd1 << i))
				code = 3'(i);
		end
		return code;
	endfunction

	logic is_nes20;
	logic upper_nonzero;
	logic is_dirty;
	byte_t mapper;

	assign is_nes20 = (header[FLAGS7_OFS][3:2] == NES20_ID);

	always_comb begin
		upper_nonzero = 1'b0;
		for (int i = MAPPER2_OFS; i < HEADER_BYTES; i++)
			upper_nonzero = upper_nonzero | (header[i] != 8'h00);
	end

	// Junk in bytes 8..15 of a 1.0 header, often a ripper's tag
	assign is_dirty = !is_nes20 && upper_nonzero;

	assign mapper = {is_dirty ? 4'h0 : header[FLAGS7_OFS][7:4], header[FLAGS6_OFS][7:4]};

	always_comb begin
		flags = '0;
		flags[MAPPER_LSB +: 8] = mapper;
		flags[PRG_SIZE_LSB +: 3] = size_code(header[PRG_PAGES_OFS]);
		flags[CHR_SIZE_LSB +: 3] = size_code(header[CHR_PAGES_OFS]);
		flags[MIRROR_BIT] = header[FLAGS6_OFS][MIRROR_SRC_BIT] ^ invert_mirroring;
		flags[CHR_RAM_BIT] = (header[CHR_PAGES_OFS] == 8'h00);
		flags[FOUR_SCREEN_BIT] = header[FLAGS6_OFS][FOUR_SCREEN_SRC_BIT];
		if (is_nes20)
			flags[NES20_MAPPER_LSB +: 8] = header[MAPPER2_OFS];
	end

endmodule

// ==== verilog/game_loader.sv ====
/*
 * Parses an iNES stream and places PRG at PRG_BASE, CHR at CHR_BASE.
 * Header bytes are also written, at addresses 0..15.
 * Bad magic or a trainer ends in the fail state with done and error set.
 */
module game_loader (
	input logic clk,
	input logic reset,
	input logic downloading,
	input logic load_strobe,
	input logic invert_mirroring,
	input nes_bus_pkg::byte_t load_data,
	output nes_bus_pkg::mem_addr_t loader_addr,
	output nes_bus_pkg::byte_t loader_data,
	output logic loader_write,
	output logic done,
	output logic error,
	output logic [31:0] mapper_flags
);
	import nes_bus_pkg::*;
	import ines_pkg::*;

	typedef enum logic [1:0] {
		ST_HEADER,
		ST_PRG,
		ST_CHR,
		ST_FAIL
	} state_t;

	state_t state;
	header_t header;
	logic [3:0] ctr;	// Header byte index
	mem_addr_t bytes_left;
	logic [31:0] decoded_flags;
	logic header_ok;

	mapper_flags_decode u_decode (
		.header(header),
		.invert_mirroring(invert_mirroring),
		.flags(decoded_flags)
	);

	assign loader_data = load_data;
	assign loader_write = load_strobe &&
		((state == ST_HEADER && downloading) ||
		((state == ST_PRG || state == ST_CHR) && bytes_left != '0));

	// Bytes 0..6 are already stored when the 16th byte arrives
	assign header_ok = header[MAGIC_0] == NES_MAGIC[0] && header[MAGIC_1] == NES_MAGIC[1] &&
		header[MAGIC_2] == NES_MAGIC[2] && header[MAGIC_3] == NES_MAGIC[3] &&
		!header[FLAGS6_OFS][TRAINER_BIT];

	always_ff @(posedge clk) begin
		if (state == ST_HEADER && loader_write)
			header[ctr] <= load_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_HEADER;
			ctr <= 4'd0;
			loader_addr <= PRG_BASE;
			bytes_left <= '0;
			done <= 1'b0;
			error <= 1'b0;
			mapper_flags <= '0;
		end else begin
			case (state)
				ST_HEADER: if (loader_write) begin
					ctr <= ctr + 4'd1;
					loader_addr <= loader_addr + mem_addr_t'(1);
					if (ctr == 4'd15) begin
						if (header_ok) begin
							state <= ST_PRG;
							loader_addr <= PRG_BASE;
							bytes_left <= mem_addr_t'(header[PRG_PAGES_OFS]) << PRG_PAGE_SHIFT;
						end else begin
							state <= ST_FAIL;
							done <= 1'b1;
							error <= 1'b1;
							mapper_flags <= decoded_flags;
						end
					end
				end
				ST_PRG, ST_CHR: begin
					if (bytes_left != '0) begin
						if (load_strobe) begin
							bytes_left <= bytes_left - mem_addr_t'(1);
							loader_addr <= loader_addr + mem_addr_t'(1);
						end
					end else if (state == ST_PRG) begin
						state <= ST_CHR;
						loader_addr <= CHR_BASE;
						bytes_left <= mem_addr_t'(header[CHR_PAGES_OFS]) << CHR_PAGE_SHIFT;
					end else if (!done) begin
						done <= 1'b1;
						mapper_flags <= decoded_flags;	// Frozen until next loader reset
					end
				end
				default: ;	// Fail holds done and error
			endcase
		end
	end

endmodule

// ==== verilog/memory_write_stage.sv ====
/*
 * Releases one loader write per four-cycle window, in the memory slot.
 * A second write inside the same window overwrites the first.
 */
module memory_write_stage (
	input logic clk,
	input logic reset,
	input logic run,
	input logic loader_write,
	input nes_bus_pkg::mem_addr_t loader_addr,
	input nes_bus_pkg::byte_t loader_data,
	output nes_bus_pkg::mem_addr_t mem_addr,
	output nes_bus_pkg::byte_t mem_data,
	output logic mem_write
);
	logic pending;

	always_ff @(posedge clk) begin
		if (loader_write) begin
			mem_addr <= loader_addr;
			mem_data <= loader_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= 1'b0;
			mem_write <= 1'b0;
		end else begin
			if (run) begin
				mem_write <= pending;	// Held for the whole console cycle
				pending <= 1'b0;
			end
			if (loader_write)
				pending <= 1'b1;	// A new write wins over the clear
		end
	end

endmodule

// ==== verilog/machine_control.sv ====
/*
 * Console clock enable and reset sources.
 * nes_reset drops 256 cycles after the last cycle with downloading high.
 */
module machine_control (
	input logic clk,
	input logic reset,
	input logic downloading,
	input logic reset_button,
	input logic loader_error,
	output logic nes_run,
	output logic nes_reset,
	output logic loader_reset
);
	import nes_bus_pkg::*;

	ce_phase_t phase;
	logic init_hold;
	reset_count_t download_cnt;

	always_ff @(posedge clk) begin
		if (reset)
			phase <= '0;
		else
			phase <= phase + ce_phase_t'(1);
	end

	// Keeps the console off until a game has been sent at least once
	always_ff @(posedge clk) begin
		if (reset)
			init_hold <= 1'b1;
		else if (downloading)
			init_hold <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (reset)
			download_cnt <= '0;
		else if (downloading)
			download_cnt <= DOWNLOAD_RESET_CYCLES;
		else if (download_cnt != '0)
			download_cnt <= download_cnt - reset_count_t'(1);
	end

	// Keeps running during reset so the console can actually reset
	assign nes_run = (phase == MEM_SLOT_PHASE);

	assign nes_reset = reset || init_hold || (download_cnt != '0) ||
		loader_error || reset_button;

	// Loader is live only during a download and its tail
	assign loader_reset = reset || (download_cnt == '0 && !downloading);

endmodule

// ==== verilog/joypad_serial.sv ====
/*
 * Two NES controller shift registers, LSB first, zero filled.
 * Strobe reloads every cycle it is high; a falling clock edge shifts.
 */
module joypad_serial (
	input logic clk,
	input logic reset,
	input nes_bus_pkg::byte_t joy_a,
	input nes_bus_pkg::byte_t joy_b,
	input logic joy_swap,
	input logic joypad_strobe,
	input logic [1:0] joypad_clock,
	output logic [1:0] joypad_data
);
	import nes_bus_pkg::*;

	byte_t shift_reg [2];
	byte_t load_val [2];
	logic [1:0] last_clock;

	assign load_val[0] = joy_swap ? joy_b : joy_a;
	assign load_val[1] = joy_swap ? joy_a : joy_b;

	always_ff @(posedge clk) begin
		if (reset) begin
			shift_reg[0] <= 8'h00;
			shift_reg[1] <= 8'h00;
			last_clock <= 2'b00;
		end else begin
			for (int n = 0; n < 2; n++) begin
				if (joypad_strobe)
					shift_reg[n] <= load_val[n];
				// Shift takes priority when both happen
				if (!joypad_clock[n] && last_clock[n])
					shift_reg[n] <= {1'b0, shift_reg[n][7:1]};
			end
			last_clock <= joypad_clock;
		end
	end

	assign joypad_data[0] = shift_reg[0][0];
	assign joypad_data[1] = shift_reg[1][0];

endmodule

// ==== verilog/nes_loader_top.sv ====
/*
 * Cartridge loader and controller side of the console wrapper.
 * Memory writes appear in the nes_run slot, one per four cycles at most.
 */
module nes_loader_top (
	input logic clk,
	input logic reset,
	input logic reset_button,
	input logic downloading,
	input logic load_strobe,
	input logic invert_mirroring,
	input logic [7:0] load_data,
	input logic [7:0] joy_a,
	input logic [7:0] joy_b,
	input logic joy_swap,
	input logic joypad_strobe,
	input logic [1:0] joypad_clock,
	output logic [21:0] mem_addr,
	output logic [7:0] mem_data,
	output logic mem_write,
	output logic [31:0] mapper_flags,
	output logic loader_done,
	output logic loader_error,
	output logic nes_reset,
	output logic nes_run,
	output logic [1:0] joypad_data
);
	logic loader_reset;
	logic [21:0] loader_addr;
	logic [7:0] loader_data;
	logic loader_write;

	game_loader u_loader (
		.clk(clk),
		.reset(loader_reset),
		.downloading(downloading),
		.load_strobe(load_strobe),
		.invert_mirroring(invert_mirroring),
		.load_data(load_data),
		.loader_addr(loader_addr),
		.loader_data(loader_data),
		.loader_write(loader_write),
		.done(loader_done),
		.error(loader_error),
		.mapper_flags(mapper_flags)
	);

	memory_write_stage u_stage (
		.clk(clk),
		.reset(reset),
		.run(nes_run),
		.loader_write(loader_write),
		.loader_addr(loader_addr),
		.loader_data(loader_data),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.mem_write(mem_write)
	);

	machine_control u_control (
		.clk(clk),
		.reset(reset),
		.downloading(downloading),
		.reset_button(reset_button),
		.loader_error(loader_error),
		.nes_run(nes_run),
		.nes_reset(nes_reset),
		.loader_reset(loader_reset)
	);

	joypad_serial u_joypad (
		.clk(clk),
		.reset(nes_reset),	// Pads read zero while the console is held
		.joy_a(joy_a),
		.joy_b(joy_b),
		.joy_swap(joy_swap),
		.joypad_strobe(joypad_strobe),
		.joypad_clock(joypad_clock),
		.joypad_data(joypad_data)
	);

endmodule

// ==== verification/nes_loader_props.sv ====
/*
 * Console timing properties, bound to the memory write stage.
 * run is the console clock enable as the stage sees it.
 */
module nes_loader_props (
	input logic clk,
	input logic reset,
	input logic run,
	input logic write
);
	// One run strobe every fourth cycle
	assert property (@(posedge clk) disable iff (reset)
		run |=> !run ##1 !run ##1 !run ##1 run)
		else $error("run strobe spacing broken");

	// Staged writes move only in the memory slot
	assert property (@(posedge clk) disable iff (reset)
		(write != $past(write)) |-> $past(run))
		else $error("staged write changed outside the memory slot");
endmodule

bind memory_write_stage nes_loader_props u_stage_props (
	.clk(clk), .reset(reset), .run(run), .write(mem_write)
);

// ==== verification/tb_nes_loader.sv ====
/*
 * Random iNES loads, reset timing and joypad reads against a behavioral model.
 * Loader strobes are spaced 8 cycles apart; one staged write per console cycle.
 */
module tb_nes_loader;
	logic clk;
	logic reset, reset_button, downloading, load_strobe, invert_mirroring;
	logic [7:0] load_data, joy_a, joy_b;
	logic joy_swap, joypad_strobe;
	logic [1:0] joypad_clock;
	logic [21:0] mem_addr;
	logic [7:0] mem_data;
	logic mem_write, loader_done, loader_error, nes_reset, nes_run;
	logic [31:0] mapper_flags;
	logic [1:0] joypad_data;

	logic [15:0] lfsr = 16'd30545;
	logic [7:0] hdr [16];
	logic [21:0] exp_addr [$];
	logic [7:0] exp_data [$];
	logic prev_write = 1'b0;
	logic [1:0] run_phase = 2'd0;	// Model of the four-phase clock enable
	longint cycles = 0;
	longint cycle_limit = 2000;	// Grows with each file sent

	nes_loader_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		r = 8'h00;
		for (int i = 0; i < n; i++) begin
			r = {r[6:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: the run took more than %0d cycles", cycle_limit);
			$display("Test failed");
			$fatal(1);
		end
	end

	always @(posedge clk)
		run_phase <= reset ? 2'd0 : run_phase + 2'd1;

	// Run strobe in phase 3, and each rising edge of mem_write is the next expected write
	always @(negedge clk) begin
		check("nes_run", 32'(nes_run), 32'(run_phase == 2'd3));
		if (mem_write && !prev_write) begin
			if (exp_addr.size() == 0) begin
				$display("A memory write appeared at %0t with none expected", $time);
				$display("Test failed");
				$fatal(1);
			end
			check("mem_addr", 32'(mem_addr), 32'(exp_addr.pop_front()));
			check("mem_data", 32'(mem_data), 32'(exp_data.pop_front()));
		end
		prev_write = mem_write;
	end

	function automatic logic [2:0] size_of(input logic [7:0] pages);
		int c;
		c = 0;
		while (c < 7 && (9'd1 << c) < 9'(pages))
			c++;
		return 3'(c);
	endfunction

	function automatic logic [31:0] model_flags(input logic inv);
		logic nes20, dirty;
		logic [31:0] f;
		nes20 = hdr[7][3:2] == 2'b10;
		dirty = 1'b0;
		for (int i = 8; i < 16; i++)
			dirty = dirty | (hdr[i] != 8'h00);
		dirty = dirty && !nes20;
		f = {24'h0, dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
		f[10:8] = size_of(hdr[4]);
		f[13:11] = size_of(hdr[5]);
		f[14] = hdr[6][0] ^ inv;
		f[15] = hdr[5] == 8'h00;
		f[16] = hdr[6][3];
		if (nes20)
			f[24:17] = hdr[8];
		return f;
	endfunction

	task automatic send_byte(input logic [7:0] b, input logic [21:0] addr);
		exp_addr.push_back(addr);
		exp_data.push_back(b);
		@(posedge clk);
		#1 load_data = b;
		load_strobe = 1'b1;
		@(posedge clk);
		#1 load_strobe = 1'b0;
		repeat (6) @(posedge clk);
	endtask

	// kind: 0 clean 1.0, 1 dirty 1.0, 2 iNES 2.0, 3 bad magic, 4 trainer
	task automatic run_load(input int kind, input logic inv);
		int prg_bytes, chr_bytes;
		logic bad;
		logic [3:0] mapper_hi;
		logic [1:0] flags7_low;
		bad = kind >= 3;
		hdr[0] = 8'h4E;
		hdr[1] = (kind == 3) ? 8'h46 : 8'h45;
		hdr[2] = 8'h53;
		hdr[3] = 8'h1A;
		hdr[4] = 8'd1 + rand_bits(1);
		hdr[5] = rand_bits(1);
		hdr[6] = rand_bits(8) & 8'hFB;
		if (kind == 4)
			hdr[6][2] = 1'b1;
		mapper_hi = 4'(rand_bits(4));
		flags7_low = 2'(rand_bits(2));
		hdr[7] = {mapper_hi, (kind == 2) ? 2'b10 : 2'b00, flags7_low};
		for (int i = 8; i < 16; i++)
			hdr[i] = (kind == 0) ? 8'h00 : rand_bits(8);
		if (kind == 1)
			hdr[12] = hdr[12] | 8'h01;	// At least one junk byte
		prg_bytes = bad ? 0 : int'(hdr[4]) << 14;
		chr_bytes = bad ? 0 : int'(hdr[5]) << 13;
		cycle_limit += longint'(16 + prg_bytes + chr_bytes) * 10;
		@(posedge clk);
		#1 invert_mirroring = inv;
		downloading = 1'b1;
		for (int i = 0; i < 16; i++)
			send_byte(hdr[i], 22'(i));
		for (int i = 0; i < prg_bytes; i++)
			send_byte(rand_bits(8), 22'(i));
		for (int i = 0; i < chr_bytes; i++)
			send_byte(rand_bits(8), 22'h200000 + 22'(i));
		do @(negedge clk); while (!loader_done);
		check("loader_error", 32'(loader_error), 32'(bad));
		if (!bad)
			check("mapper_flags", mapper_flags, model_flags(inv));
		@(posedge clk);
		#1 downloading = 1'b0;
		// Counter was loaded with 255 at the last high cycle
		for (int i = 1; i <= 256; i++) begin
			@(negedge clk);
			check("nes_reset", 32'(nes_reset), 32'(i < 256 || bad));
		end
		check("pending_writes", 32'(exp_addr.size()), 32'd0);
		repeat (2) @(posedge clk);
	endtask

	task automatic joypad_test(input logic swap);
		logic [7:0] port_val [2];
		@(posedge clk);
		#1 joy_a = rand_bits(8);
		joy_b = rand_bits(8);
		joy_swap = swap;
		joypad_strobe = 1'b1;
		port_val[0] = swap ? joy_b : joy_a;
		port_val[1] = swap ? joy_a : joy_b;
		@(posedge clk);
		#1 joypad_strobe = 1'b0;
		for (int k = 0; k < 10; k++) begin
			@(negedge clk);
			check("joypad_data[0]", 32'(joypad_data[0]), 32'((port_val[0] >> k) & 8'h01));
			check("joypad_data[1]", 32'(joypad_data[1]), 32'((port_val[1] >> k) & 8'h01));
			@(posedge clk);
			#1 joypad_clock = 2'b11;
			@(posedge clk);
			#1 joypad_clock = 2'b00;
			@(posedge clk);
		end
	endtask

	initial begin
		reset = 1'b1;
		reset_button = 1'b0;
		downloading = 1'b0;
		load_strobe = 1'b0;
		invert_mirroring = 1'b0;
		load_data = 8'h00;
		joy_a = 8'h00;
		joy_b = 8'h00;
		joy_swap = 1'b0;
		joypad_strobe = 1'b0;
		joypad_clock = 2'b00;
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
		joy_a = 8'hFF;
		joy_b = 8'hFF;
		joypad_strobe = 1'b1;	// Pads stay cleared while the console is held
		repeat (6) @(negedge clk);
		check("nes_reset", 32'(nes_reset), 32'd1);	// Init hold before any download
		check("mem_write", 32'(mem_write), 32'd0);
		check("joypad_data", 32'(joypad_data), 32'd0);
		@(posedge clk);
		#1 joypad_strobe = 1'b0;
		run_load(0, 1'b0);
		@(posedge clk);
		#1 joypad_strobe = 1'b1;
		@(posedge clk);
		#1 joypad_strobe = 1'b0;
		reset_button = 1'b1;
		@(negedge clk);
		check("nes_reset", 32'(nes_reset), 32'd1);
		check("joypad_data", 32'(joypad_data), 32'd3);	// Loaded before the button
		@(negedge clk);
		check("joypad_data", 32'(joypad_data), 32'd0);
		@(posedge clk);
		#1 reset_button = 1'b0;
		@(negedge clk);
		check("nes_reset", 32'(nes_reset), 32'd0);
		joypad_test(1'b0);
		joypad_test(1'b1);
		run_load(1, 1'b1);
		run_load(2, 1'b0);
		run_load(0, 1'b1);
		run_load(3, 1'b0);
		run_load(4, 1'b1);
		$display("Test passed");
		$finish;
	end

endmodule

// ==== compile.f ====
verilog/nes_bus_pkg.sv
verilog/ines_pkg.sv
verilog/mapper_flags_decode.sv
verilog/game_loader.sv
verilog/memory_write_stage.sv
verilog/machine_control.sv
verilog/joypad_serial.sv
verilog/nes_loader_top.sv
verification/nes_loader_props.sv
verification/tb_nes_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal -f compile.f --top-module tb_nes_loader \
	-o sim_tb_nes_loader
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb_nes_loader > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Pass message not found in $LOG"
	exit 1
fi
